// ==== src/video_consts.svh ====
// Frame geometry, blanking, memory layout and FIFO depth defines, included by RTL and testbench
`ifndef VIDEO_CONSTS_SVH
`define VIDEO_CONSTS_SVH

// ========================================
// Camera and display frame size
// ========================================
`define CAM_W 8                  // Pixels per camera line
`define CAM_H 4                  // Lines per camera frame
`define DISP_W (`CAM_W * 2)      // Both cameras side by side

// ========================================
// Blanking intervals
// ========================================
`define H_FP 2                   // Horizontal front porch in pixels
`define H_SYNC 4                 // Horizontal sync width
`define H_BP 2                   // Horizontal back porch
`define H_TOTAL (`DISP_W + `H_FP + `H_SYNC + `H_BP)

`define V_FP 1                   // Vertical front porch in lines
`define V_SYNC 2                 // Vertical sync width
`define V_BP 1                   // Vertical back porch
`define V_TOTAL (`CAM_H + `V_FP + `V_SYNC + `V_BP)

// ========================================
// Frame memory layout and buffering
// ========================================
`define CAM1_BASE 0              // Region written by camera 1
`define CAM2_BASE 32             // Region written by camera 2
`define MEM_WORDS 64             // One pixel per word
`define FIFO_DEPTH 8             // Power of two

`endif

// ==== src/video_pkg.sv ====
// Pixel and camera byte types shared by the capture, display and output stages
package video_pkg;

	// Raw byte from the camera data bus
	typedef logic [7:0] cam_byte_t;

	// Pixel as the camera sends it over two bytes
	typedef struct packed {
		logic [4:0] r;    // High byte bits 7..3
		logic [5:0] g;    // Split over both bytes
		logic [4:0] b;    // Low byte bits 4..0
	} rgb565_t;

	// Full width pixel as stored in memory and sent to HDMI
	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} pixel_t;

endpackage

// ==== src/mem_pkg.sv ====
// Address, requester and write-entry types for the shared frame memory
`include "video_consts.svh"

package mem_pkg;

	// Word address into the frame memory
	typedef logic [$clog2(`MEM_WORDS)-1:0] mem_addr_t;

	// Peers on the arbiter, in round-robin order
	typedef enum logic [1:0] {
		req_cam1    = 2'd0,
		req_cam2    = 2'd1,
		req_display = 2'd2
	} req_id_t;

	// Write waiting in a camera FIFO
	typedef struct packed {
		mem_addr_t          addr;  // Absolute memory address
		video_pkg::pixel_t  data;  // Widened pixel
	} mem_wr_t;

endpackage

// ==== src/sync_fifo.sv ====
// Single-clock first-word fall-through FIFO with the payload type set per instance
`include "video_consts.svh"

module sync_fifo #(
	parameter type payload_t = logic [7:0]
) (
	input  logic                                  clk_25_2m,
	input  logic                                  reset,
	input  logic                                  push,
	input  payload_t                              push_data,
	input  logic                                  pop,
	output payload_t                              pop_data,
	output logic                                  empty,
	output logic                                  full,
	output logic [$clog2(`FIFO_DEPTH + 1)-1:0]    count
);

	localparam int DEPTH = `FIFO_DEPTH;
	localparam int AW = $clog2(DEPTH);          // Pointers wrap on their own

	payload_t       mem [DEPTH];
	logic [AW-1:0]  wr_ptr;
	logic [AW-1:0]  rd_ptr;

	// Storage array
	always_ff @(posedge clk_25_2m) begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk_25_2m) begin
		if (!reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // Both or neither
			endcase
		end
	end

	assign pop_data = mem[rd_ptr];              // Head visible without a pop
	assign empty    = (count == '0);
	assign full     = (count == ($bits(count))'(DEPTH));

	// Producers size their traffic so neither case can happen
	a_no_overflow: assert property (@(posedge clk_25_2m) disable iff (!reset)
		!(push && full));
	a_no_underflow: assert property (@(posedge clk_25_2m) disable iff (!reset)
		!(pop && empty));

endmodule

// ==== src/cam_capture.sv ====
// One camera port, turns RGB565 byte pairs into queued RGB888 memory writes
`include "video_consts.svh"

module cam_capture #(
	parameter mem_pkg::mem_addr_t BASE = '0  // Start of this camera's region
) (
	input  logic                    clk_25_2m,
	input  logic                    reset,
	input  logic                    vsync,
	input  logic                    href,
	input  video_pkg::cam_byte_t    data,
	input  logic                    wr_ready,
	output logic                    wr_valid,
	output mem_pkg::mem_addr_t      wr_addr,
	output video_pkg::pixel_t       wr_data,
	output logic                    frame_done
);

	localparam int FRAME_PIX = `CAM_W * `CAM_H;
	localparam int CW = $clog2(FRAME_PIX + 1);

	logic                   vsync_d;
	logic                   vs_rise;
	logic                   phase;      // High once the first byte is held
	video_pkg::cam_byte_t   hi_byte;
	video_pkg::rgb565_t     px565;
	video_pkg::pixel_t      px888;
	mem_pkg::mem_addr_t     pix_cnt;    // Pixels assembled this frame
	mem_pkg::mem_wr_t       entry;
	mem_pkg::mem_wr_t       head;
	logic                   push;
	logic                   empty;
	logic [CW-1:0]          wr_cnt;     // Writes accepted by the arbiter

	// ========================================
	// Byte pairing
	// ========================================
	assign vs_rise = vsync && !vsync_d;
	assign push    = href && phase;     // Second byte completes a pixel

	always_ff @(posedge clk_25_2m) begin
		if (!reset) begin
			vsync_d <= 1'b0;
			phase   <= 1'b0;
			pix_cnt <= '0;
		end else begin
			vsync_d <= vsync;
			if (vs_rise) begin          // New frame restarts the region
				phase   <= 1'b0;
				pix_cnt <= '0;
			end else if (href) begin
				phase <= !phase;
				if (phase)
					pix_cnt <= pix_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk_25_2m) begin
		if (href && !phase)
			hi_byte <= data;
	end

	// Widen by repeating the top bits into the empty low bits
	always_comb begin
		px565      = video_pkg::rgb565_t'({hi_byte, data});
		px888.r    = {px565.r, px565.r[4:2]};
		px888.g    = {px565.g, px565.g[5:4]};
		px888.b    = {px565.b, px565.b[4:2]};
		entry.addr = BASE + pix_cnt;
		entry.data = px888;
	end

	// ========================================
	// Write queue and request
	// ========================================
	sync_fifo #(.payload_t(mem_pkg::mem_wr_t)) wr_fifo (
		.clk_25_2m (clk_25_2m),
		.reset     (reset),
		.push      (push),
		.push_data (entry),
		.pop       (wr_valid && wr_ready),
		.pop_data  (head),
		.empty     (empty),
		.full      (),
		.count     ()
	);

	assign wr_valid = !empty;           // Head stays put until accepted
	assign wr_addr  = head.addr;
	assign wr_data  = head.data;

	always_ff @(posedge clk_25_2m) begin
		if (!reset) begin
			wr_cnt     <= '0;
			frame_done <= 1'b0;
		end else if (vs_rise) begin
			wr_cnt     <= '0;
			frame_done <= 1'b0;
		end else if (wr_valid && wr_ready) begin
			wr_cnt <= wr_cnt + 1'b1;
			if (wr_cnt == CW'(FRAME_PIX - 1))
				frame_done <= 1'b1;     // Last pixel of the frame is in memory
		end
	end

	a_wr_hold: assert property (@(posedge clk_25_2m) disable iff (!reset)
		wr_valid && !wr_ready |=> wr_valid && $stable(wr_data) && $stable(wr_addr));

endmodule

// ==== src/frame_mem_arbiter.sv ====
// Round-robin arbiter for two camera writers and the display reader over the frame memory
`include "video_consts.svh"

module frame_mem_arbiter (
	input  logic                  clk_25_2m,
	input  logic                  reset,
	input  logic                  wr_valid_1,
	input  mem_pkg::mem_addr_t    wr_addr_1,
	input  video_pkg::pixel_t     wr_data_1,
	input  logic                  wr_valid_2,
	input  mem_pkg::mem_addr_t    wr_addr_2,
	input  video_pkg::pixel_t     wr_data_2,
	input  logic                  rd_req_valid,
	input  mem_pkg::mem_addr_t    rd_addr,
	output logic                  wr_ready_1,
	output logic                  wr_ready_2,
	output logic                  rd_req_ready,
	output logic                  rd_data_valid,
	output video_pkg::pixel_t     rd_data
);

	video_pkg::pixel_t  mem [`MEM_WORDS];
	mem_pkg::req_id_t   last_grant;
	mem_pkg::req_id_t   grant;
	logic               grant_vld;
	logic [2:0]         req;            // Indexed by requester id

	assign req = {rd_req_valid, wr_valid_2, wr_valid_1};

	// ========================================
	// Grant selection
	// ========================================
	always_comb begin
		int idx;
		grant     = mem_pkg::req_cam1;
		grant_vld = 1'b0;
		// Search starts just after the last winner
		for (int i = 1; i <= 3; i++) begin
			idx = (int'(last_grant) + i) % 3;
			if (!grant_vld && req[idx]) begin
				grant     = mem_pkg::req_id_t'(idx);
				grant_vld = 1'b1;
			end
		end
	end

	assign wr_ready_1   = grant_vld && (grant == mem_pkg::req_cam1);
	assign wr_ready_2   = grant_vld && (grant == mem_pkg::req_cam2);
	assign rd_req_ready = grant_vld && (grant == mem_pkg::req_display);

	always_ff @(posedge clk_25_2m) begin
		if (!reset) begin
			last_grant    <= mem_pkg::req_display;  // Camera 1 goes first
			rd_data_valid <= 1'b0;
		end else begin
			if (grant_vld)
				last_grant <= grant;
			rd_data_valid <= rd_req_ready;          // Fixed one cycle latency
		end
	end

	// ========================================
	// Memory array
	// ========================================
	always_ff @(posedge clk_25_2m) begin
		if (wr_ready_1)
			mem[wr_addr_1] <= wr_data_1;
		if (wr_ready_2)
			mem[wr_addr_2] <= wr_data_2;
		if (rd_req_ready)
			rd_data <= mem[rd_addr];
	end

	a_one_grant: assert property (@(posedge clk_25_2m) disable iff (!reset)
		$onehot0({wr_ready_1, wr_ready_2, rd_req_ready}));

endmodule

// ==== src/video_timing.sv ====
// Progressive video timing generator, starts at the first active pixel when run rises
`include "video_consts.svh"

module video_timing (
	input  logic clk_25_2m,
	input  logic reset,
	input  logic run,
	output logic de,
	output logic hs,
	output logic vs
);

	localparam int HW = $clog2(`H_TOTAL);
	localparam int VW = $clog2(`V_TOTAL);

	// Region edges along a line
	localparam int HS_START = `DISP_W + `H_FP;
	localparam int HS_END   = HS_START + `H_SYNC;
	// Region edges down a frame
	localparam int VS_START = `CAM_H + `V_FP;
	localparam int VS_END   = VS_START + `V_SYNC;

	logic [HW-1:0] x;
	logic [VW-1:0] y;
	logic          line_end;
	logic          frame_end;

	assign line_end  = (x == HW'(`H_TOTAL - 1));
	assign frame_end = (y == VW'(`V_TOTAL - 1));

	// ========================================
	// Counters
	// ========================================
	always_ff @(posedge clk_25_2m) begin
		if (!reset || !run) begin       // Parked at the origin until started
			x <= '0;
			y <= '0;
		end else if (line_end) begin
			x <= '0;
			if (frame_end)
				y <= '0;
			else
				y <= y + 1'b1;
		end else begin
			x <= x + 1'b1;
		end
	end

	// ========================================
	// Region decode
	// ========================================
	assign de = run
		&& (x < HW'(`DISP_W))
		&& (y < VW'(`CAM_H));               // Active picture

	assign hs = run
		&& (x >= HW'(HS_START))
		&& (x < HW'(HS_END));               // After the front porch

	// Sync spans whole lines, blanking lines only
	assign vs = run
		&& (y >= VW'(VS_START))
		&& (y <= VW'(VS_END - 1));

endmodule

// ==== src/display_reader.sv ====
// Display side reader, prefetches side-by-side pixels from both regions for the video output
`include "video_consts.svh"

module display_reader (
	input  logic                  clk_25_2m,
	input  logic                  reset,
	input  logic                  cam1_done,
	input  logic                  cam2_done,
	input  logic                  rd_req_ready,
	input  logic                  rd_data_valid,
	input  video_pkg::pixel_t     rd_data,
	input  logic                  pixel_req,
	output logic                  rd_req_valid,
	output mem_pkg::mem_addr_t    rd_addr,
	output logic                  timing_run,
	output video_pkg::pixel_t     pixel
);

	localparam int XW = $clog2(`DISP_W);
	localparam int YW = $clog2(`CAM_H);
	localparam int CW = $clog2(`FIFO_DEPTH + 1);

	logic            fetch_en;      // Both frames are in memory
	logic            reads_done;    // One full frame has been requested
	logic [XW-1:0]   rx;
	logic [YW-1:0]   ry;
	logic            rd_fire;
	logic            last_addr;
	logic            fifo_full;
	logic [CW-1:0]   fifo_count;

	// ========================================
	// Address walk
	// ========================================
	always_comb begin
		if (rx < XW'(`CAM_W))       // Left half from camera 1
			rd_addr = mem_pkg::mem_addr_t'(`CAM1_BASE + ry * `CAM_W + rx);
		else                        // Right half from camera 2
			rd_addr = mem_pkg::mem_addr_t'(`CAM2_BASE + ry * `CAM_W + rx - `CAM_W);
	end

	// Room must cover the read whose data is still on its way
	assign rd_req_valid = fetch_en
		&& ((int'(fifo_count) + int'(rd_data_valid)) < `FIFO_DEPTH);
	assign rd_fire   = rd_req_valid && rd_req_ready;
	assign last_addr = (rx == XW'(`DISP_W - 1)) && (ry == YW'(`CAM_H - 1));

	always_ff @(posedge clk_25_2m) begin
		if (!reset) begin
			rx <= '0;
			ry <= '0;
		end else if (rd_fire) begin
			if (rx == XW'(`DISP_W - 1)) begin
				rx <= '0;
				ry <= ry + 1'b1;    // Wraps to line 0 after the frame
			end else begin
				rx <= rx + 1'b1;
			end
		end
	end

	// ========================================
	// Start control
	// ========================================
	always_ff @(posedge clk_25_2m) begin
		if (!reset) begin
			fetch_en   <= 1'b0;
			reads_done <= 1'b0;
			timing_run <= 1'b0;
		end else begin
			if (cam1_done && cam2_done)
				fetch_en <= 1'b1;
			if (rd_fire && last_addr)
				reads_done <= 1'b1;
			if (fetch_en && (fifo_full || reads_done))
				timing_run <= 1'b1; // Primed, runs from here on
		end
	end

	sync_fifo #(.payload_t(video_pkg::pixel_t)) pix_fifo (
		.clk_25_2m (clk_25_2m),
		.reset     (reset),
		.push      (rd_data_valid),
		.push_data (rd_data),
		.pop       (pixel_req),
		.pop_data  (pixel),
		.empty     (),
		.full      (fifo_full),
		.count     (fifo_count)
	);

endmodule

// ==== src/stereo_cap_top.sv ====
// Top level of the stereo capture path, cameras into shared memory and out as side-by-side HDMI
`include "video_consts.svh"

module stereo_cap_top (
	input  logic                    clk_25_2m,
	input  logic                    reset,
	input  logic                    cam1_vsync,
	input  logic                    cam1_href,
	input  video_pkg::cam_byte_t    cam1_data,
	input  logic                    cam2_vsync,
	input  logic                    cam2_href,
	input  video_pkg::cam_byte_t    cam2_data,
	output logic                    hdmi_de,
	output logic                    hdmi_hs,
	output logic                    hdmi_vs,
	output video_pkg::pixel_t       hdmi_d
);

	logic                 wr_valid_1, wr_ready_1, wr_valid_2, wr_ready_2;
	mem_pkg::mem_addr_t   wr_addr_1, wr_addr_2, rd_addr;
	video_pkg::pixel_t    wr_data_1, wr_data_2, rd_data, pixel;
	logic                 cam1_done, cam2_done;
	logic                 rd_req_valid, rd_req_ready, rd_data_valid;
	logic                 timing_run, de, hs, vs;

	// ========================================
	// Capture ports
	// ========================================
	cam_capture #(.BASE(mem_pkg::mem_addr_t'(`CAM1_BASE))) capture_cam1 (
		.clk_25_2m (clk_25_2m), .reset (reset),
		.vsync (cam1_vsync), .href (cam1_href), .data (cam1_data),
		.wr_ready (wr_ready_1), .wr_valid (wr_valid_1),
		.wr_addr (wr_addr_1), .wr_data (wr_data_1), .frame_done (cam1_done)
	);

	cam_capture #(.BASE(mem_pkg::mem_addr_t'(`CAM2_BASE))) capture_cam2 (
		.clk_25_2m (clk_25_2m), .reset (reset),
		.vsync (cam2_vsync), .href (cam2_href), .data (cam2_data),
		.wr_ready (wr_ready_2), .wr_valid (wr_valid_2),
		.wr_addr (wr_addr_2), .wr_data (wr_data_2), .frame_done (cam2_done)
	);

	frame_mem_arbiter mem_arb (
		.clk_25_2m (clk_25_2m), .reset (reset),
		.wr_valid_1 (wr_valid_1), .wr_addr_1 (wr_addr_1), .wr_data_1 (wr_data_1),
		.wr_valid_2 (wr_valid_2), .wr_addr_2 (wr_addr_2), .wr_data_2 (wr_data_2),
		.rd_req_valid (rd_req_valid), .rd_addr (rd_addr),
		.wr_ready_1 (wr_ready_1), .wr_ready_2 (wr_ready_2), .rd_req_ready (rd_req_ready),
		.rd_data_valid (rd_data_valid), .rd_data (rd_data)
	);

	// ========================================
	// Display side
	// ========================================
	display_reader reader (
		.clk_25_2m (clk_25_2m), .reset (reset),
		.cam1_done (cam1_done), .cam2_done (cam2_done),
		.rd_req_ready (rd_req_ready), .rd_data_valid (rd_data_valid), .rd_data (rd_data),
		.pixel_req (de), .rd_req_valid (rd_req_valid), .rd_addr (rd_addr),
		.timing_run (timing_run), .pixel (pixel)
	);

	video_timing timing (
		.clk_25_2m (clk_25_2m), .reset (reset), .run (timing_run),
		.de (de), .hs (hs), .vs (vs)
	);

	// Output register keeps data in step with de
	always_ff @(posedge clk_25_2m) begin
		if (!reset) begin
			hdmi_de <= 1'b0;
			hdmi_hs <= 1'b0;
			hdmi_vs <= 1'b0;
			hdmi_d  <= '0;
		end else begin
			hdmi_de <= de;
			hdmi_hs <= hs;
			hdmi_vs <= vs;
			hdmi_d  <= de ? pixel : '0;   // Black during blanking
		end
	end

endmodule

// ==== verification/tb_clock.sv ====
// Clock and reset source for the testbench, free running clock and a reset held low at start
module tb_clock #(
	parameter int PERIOD       = 40,   // Clock period in time units
	parameter int RESET_CYCLES = 5     // Rising edges with reset held low
) (
	output logic clk_25_2m,
	output logic reset
);

	initial begin
		clk_25_2m = 1'b0;
		forever #(PERIOD / 2) clk_25_2m = ~clk_25_2m;
	end

	initial begin
		reset = 1'b0;                   // Active low, asserted from time zero
		repeat (RESET_CYCLES) @(posedge clk_25_2m);
		reset <= 1'b1;
	end

endmodule

// ==== verification/stereo_cap_checker.sv ====
// Watches the HDMI outputs of the stereo capture top and checks pixels and timing per test
`include "video_consts.svh"

module stereo_cap_checker (
	input  logic               clk_25_2m,
	input  logic               reset,
	input  logic               hdmi_de,
	input  logic               hdmi_hs,
	input  logic               hdmi_vs,
	input  video_pkg::pixel_t  hdmi_d,
	input  logic               cam1_only,                    // Camera 1 done, camera 2 not yet
	input  video_pkg::pixel_t  exp_frame [`DISP_W * `CAM_H], // Expected side-by-side frame
	output logic               done,
	output int                 fail_total
);

	localparam int T_QUIET  = 0;
	localparam int T_LEFT   = 1;
	localparam int T_RIGHT  = 2;
	localparam int T_TIMING = 3;
	localparam int T_REPEAT = 4;
	localparam int N_TESTS  = 5;
	localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;

	int   errs [N_TESTS];
	int   line_px;          // de cycles so far in this line
	int   line_cnt;         // Active lines so far in this frame
	int   hs_len;
	int   hs_pulses;
	int   vs_gap;           // Cycles since the last vs rise
	int   vs_rises;
	int   alone_cycles;     // Quiet cycles with only camera 1 done
	int   failed;
	int   idx;
	logic de_q;
	logic hs_q;
	logic vs_q;
	logic started;          // First de seen

	function automatic string test_name(input int t);
		case (t)
			T_QUIET:  return "quiet_outputs";
			T_LEFT:   return "left_half";
			T_RIGHT:  return "right_half";
			T_TIMING: return "line_frame_timing";
			default:  return "frame_repeat";
		endcase
	endfunction

	task automatic value_error(input int t, input logic [23:0] expected, input logic [23:0] actual);
		$display("FAIL %s expected %h actual %h", test_name(t), expected, actual);
		errs[t]++;
	endtask

	task automatic count_error(input int t, input string what, input int expected, input int actual);
		$display("FAIL %s %s expected %0d actual %0d", test_name(t), what, expected, actual);
		errs[t]++;
	endtask

	task automatic problem(input int t, input string msg);
		$display("ERROR %s %s", test_name(t), msg);
		errs[t]++;
	endtask

	task automatic finish_test(input int t);
		if (errs[t] == 0) begin
			$display("Test %s passed", test_name(t));
		end else begin
			$display("Test %s failed with %0d errors", test_name(t), errs[t]);
			failed++;
		end
	endtask

	// ========================================
	// Output monitor
	// ========================================
	always @(posedge clk_25_2m) begin
		if (!reset) begin
			line_px      = 0;
			line_cnt     = 0;
			hs_len       = 0;
			hs_pulses    = 0;
			vs_gap       = 0;
			vs_rises     = 0;
			alone_cycles = 0;
			failed       = 0;
			de_q         = 1'b0;
			hs_q         = 1'b0;
			vs_q         = 1'b0;
			started      = 1'b0;
			for (int t = 0; t < N_TESTS; t++)
				errs[t] = 0;
			done       <= 1'b0;
			fail_total <= 0;
		end else if (!done) begin
			// Before the first de everything must stay idle
			if (!started) begin
				if (cam1_only)
					alone_cycles++;
				if (hdmi_de) begin
					started = 1'b1;
					if (cam1_only)
						problem(T_QUIET, "display started while only camera 1 was done");
					if (alone_cycles == 0)
						problem(T_QUIET, "display started without camera 1 ever being done alone");
					finish_test(T_QUIET);
				end else begin
					if (hdmi_hs || hdmi_vs)
						count_error(T_QUIET, "hs and vs", 0, {hdmi_hs, hdmi_vs});
					if (hdmi_d != '0)
						value_error(T_QUIET, 24'h0, hdmi_d);
				end
			end

			if (started) begin
				vs_gap++;
				if (hdmi_de) begin
					if (line_px < `DISP_W && line_cnt < `CAM_H) begin
						idx = line_cnt * `DISP_W + line_px;
						// Both displayed frames must show the stored camera frames
						if (hdmi_d !== exp_frame[idx]) begin
							if (vs_rises == 0)
								value_error(line_px < `CAM_W ? T_LEFT : T_RIGHT,
									exp_frame[idx], hdmi_d);
							else
								value_error(T_REPEAT, exp_frame[idx], hdmi_d);
						end
					end
					line_px++;
				end else if (de_q) begin              // Falling de closes a line
					if (line_px != `DISP_W)
						count_error(T_TIMING, "de cycles in line", `DISP_W, line_px);
					line_px = 0;
					line_cnt++;
				end

				if (hdmi_hs) begin
					hs_len++;
				end else if (hs_q) begin
					if (hs_len != `H_SYNC)
						count_error(T_TIMING, "hs pulse length", `H_SYNC, hs_len);
					hs_len = 0;
					hs_pulses++;
				end

				// vs rise marks the end of a frame's active lines
				if (hdmi_vs && !vs_q) begin
					if (vs_rises > 0 && vs_gap != FRAME_CYCLES)
						count_error(T_TIMING, "cycles between vs rises", FRAME_CYCLES, vs_gap);
					if (line_cnt != `CAM_H)
						count_error(T_TIMING, "active lines in frame", `CAM_H, line_cnt);
					vs_gap   = 0;
					line_cnt = 0;
					vs_rises++;
					if (vs_rises == 1) begin
						finish_test(T_LEFT);
						finish_test(T_RIGHT);
					end else begin
						if (hs_pulses == 0)
							problem(T_TIMING, "no hs pulse was seen");
						finish_test(T_TIMING);
						finish_test(T_REPEAT);
						$display("Tests run %0d, passed %0d, failed %0d",
							N_TESTS, N_TESTS - failed, failed);
						fail_total <= failed;
						done       <= 1'b1;
					end
				end
			end

			de_q = hdmi_de;
			hs_q = hdmi_hs;
			vs_q = hdmi_vs;
		end
	end

endmodule

// ==== verification/stereo_cap_tb.sv ====
// Testbench top for the stereo capture path, drives both cameras and checks the side-by-side output
`include "video_consts.svh"

module stereo_cap_tb;

	localparam int NBYTES      = 2 * `CAM_W * `CAM_H;  // Two bytes per camera pixel
	localparam int NDISP       = `DISP_W * `CAM_H;
	localparam int HOLD_CYCLES = 8;                    // Window with only camera 1 done
	// Capture about 300 cycles with gaps, two displayed frames 384, the rest is margin
	localparam int TIMEOUT_CYCLES = 2000;

	logic                  clk_25_2m;
	logic                  reset;
	logic                  cam1_vsync;
	logic                  cam1_href;
	video_pkg::cam_byte_t  cam1_data;
	logic                  cam2_vsync;
	logic                  cam2_href;
	video_pkg::cam_byte_t  cam2_data;
	logic                  hdmi_de;
	logic                  hdmi_hs;
	logic                  hdmi_vs;
	video_pkg::pixel_t     hdmi_d;
	logic                  cam1_only;
	logic                  done;
	int                    fail_total;
	int                    cycles;
	integer                seed = 32'h90b66266;

	video_pkg::cam_byte_t  cam_bytes [2][NBYTES];  // Bytes sent per camera, high byte first
	int                    gaps [2][NBYTES];       // Idle href cycles before each byte
	video_pkg::pixel_t     exp_frame [NDISP];

	tb_clock #(.PERIOD(40), .RESET_CYCLES(5)) clock_gen (
		.clk_25_2m (clk_25_2m),
		.reset     (reset)
	);

	stereo_cap_top DUT (
		.clk_25_2m (clk_25_2m), .reset (reset),
		.cam1_vsync (cam1_vsync), .cam1_href (cam1_href), .cam1_data (cam1_data),
		.cam2_vsync (cam2_vsync), .cam2_href (cam2_href), .cam2_data (cam2_data),
		.hdmi_de (hdmi_de), .hdmi_hs (hdmi_hs), .hdmi_vs (hdmi_vs), .hdmi_d (hdmi_d)
	);

	assign cam1_only = DUT.cam1_done && !DUT.cam2_done;

	stereo_cap_checker out_check (
		.clk_25_2m (clk_25_2m), .reset (reset),
		.hdmi_de (hdmi_de), .hdmi_hs (hdmi_hs), .hdmi_vs (hdmi_vs), .hdmi_d (hdmi_d),
		.cam1_only (cam1_only), .exp_frame (exp_frame),
		.done (done), .fail_total (fail_total)
	);

	// ========================================
	// Reference model
	// ========================================
	// Puts a w-bit field at the top of a byte and refills the low bits from its own MSBs
	function automatic logic [7:0] widen_msb(input logic [7:0] v, input int w);
		return 8'((v << (8 - w)) | (v >> (2 * w - 8)));
	endfunction

	function automatic video_pkg::pixel_t expected_pixel(input int x, input int y);
		int                 cam;
		int                 idx;
		logic [15:0]        word;
		video_pkg::pixel_t  p;
		cam  = (x < `CAM_W) ? 0 : 1;                  // Right half comes from camera 2
		idx  = 2 * (y * `CAM_W + x - cam * `CAM_W);
		word = {cam_bytes[cam][idx], cam_bytes[cam][idx + 1]};
		p.r  = widen_msb(8'(word[15:11]), 5);
		p.g  = widen_msb(8'(word[10:5]), 6);
		p.b  = widen_msb(8'(word[4:0]), 5);
		return p;
	endfunction

	// ========================================
	// Camera stimulus
	// ========================================
	task automatic drive_cam(input int cam, input logic vs, input logic hr,
		input video_pkg::cam_byte_t d);
		if (cam == 0) begin
			cam1_vsync <= vs;
			cam1_href  <= hr;
			cam1_data  <= d;
		end else begin
			cam2_vsync <= vs;
			cam2_href  <= hr;
			cam2_data  <= d;
		end
	endtask

	task automatic start_frame(input int cam);
		@(posedge clk_25_2m);
		drive_cam(cam, 1'b1, 1'b0, 8'h00);            // Rising vsync restarts the region
		repeat (2) @(posedge clk_25_2m);
		drive_cam(cam, 1'b0, 1'b0, 8'h00);
	endtask

	task automatic send_bytes(input int cam, input int first, input int last);
		for (int i = first; i <= last; i++) begin
			repeat (gaps[cam][i]) begin
				@(posedge clk_25_2m);
				drive_cam(cam, 1'b0, 1'b0, 8'h00);
			end
			@(posedge clk_25_2m);
			drive_cam(cam, 1'b0, 1'b1, cam_bytes[cam][i]);
		end
		@(posedge clk_25_2m);
		drive_cam(cam, 1'b0, 1'b0, 8'h00);
	endtask

	initial begin
		cam1_vsync = 1'b0;
		cam1_href  = 1'b0;
		cam1_data  = 8'h00;
		cam2_vsync = 1'b0;
		cam2_href  = 1'b0;
		cam2_data  = 8'h00;
		for (int c = 0; c < 2; c++) begin
			for (int i = 0; i < NBYTES; i++) begin
				cam_bytes[c][i] = 8'($random(seed));
				gaps[c][i]      = int'($unsigned($random(seed)) % 3);
			end
		end
		for (int y = 0; y < `CAM_H; y++)
			for (int x = 0; x < `DISP_W; x++)
				exp_frame[y * `DISP_W + x] = expected_pixel(x, y);
		@(posedge clk_25_2m);
		while (!reset) @(posedge clk_25_2m);
		fork
			begin
				start_frame(0);
				send_bytes(0, 0, NBYTES - 1);
			end
			begin
				start_frame(1);
				send_bytes(1, 0, NBYTES - 3);
				// Last pixel waits so camera 1 is seen done on its own
				while (!DUT.cam1_done) @(posedge clk_25_2m);
				repeat (HOLD_CYCLES) @(posedge clk_25_2m);
				send_bytes(1, NBYTES - 2, NBYTES - 1);
			end
		join
	end

	// ========================================
	// Run limit and result
	// ========================================
	initial begin
		cycles = 0;
		while (done !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
			@(posedge clk_25_2m);
			cycles++;
		end
		if (done !== 1'b1) begin
			$display("Timeout after %0d cycles, the display did not finish two frames", cycles);
			$display("Result: FAILED");
		end else if (fail_total == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+src
src/video_pkg.sv
src/mem_pkg.sv
src/sync_fifo.sv
src/cam_capture.sv
src/frame_mem_arbiter.sv
src/video_timing.sv
src/display_reader.sv
src/stereo_cap_top.sv
verification/tb_clock.sv
verification/stereo_cap_checker.sv
verification/stereo_cap_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the stereo capture testbench with Verilator, run it and check the log for a pass

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f \
	--top-module stereo_cap_tb -Mdir obj_dir -o stereo_cap_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/stereo_cap_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q "^Result: PASSED$" sim.log; then
	exit 0
fi
exit 1
